//--- flist.f
+incdir+logic
logic/nebula_pkg.sv
logic/wb_decoder.sv
logic/team_slot.sv
logic/gpio_control.sv
logic/wb_sram.sv
logic/nebula_top.sv
bench/nebula_props.sv
bench/nebula_tb.sv

//--- Bender.yml
package:
  name: nebula

sources:
  - include_dirs:
      - logic
    files:
      - logic/nebula_pkg.sv
      - logic/wb_decoder.sv
      - logic/team_slot.sv
      - logic/gpio_control.sv
      - logic/wb_sram.sv
      - logic/nebula_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/nebula_props.sv
      - bench/nebula_tb.sv

//--- bench/nebula_tb.sv
// User area testbench
// Wishbone traffic and random pad inputs checked against a register model

`default_nettype none

`include "nebula_defs.svh"

module nebula_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int GPIO_W = `NEBULA_GPIO_W;
    localparam int NUM_TEAMS = `NEBULA_NUM_TEAMS;
    localparam int NUM_SUBS = `NEBULA_SLOT_TEAM0 + `NEBULA_NUM_TEAMS; // First unmapped slot
    localparam int SRAM_WORDS = 16;
    localparam int SRAM_PATCHES = 24;
    localparam int TEAM_REGS = 5; // OUT through INV
    localparam int PAD_SAMPLES = 4;
    localparam int UNMAPPED = 3;
    localparam int NUM_TXNS = 1 + 2 * SRAM_WORDS + SRAM_PATCHES + NUM_TEAMS * (2 * TEAM_REGS + 1)
                              + 4 * (2 + PAD_SAMPLES) + 2 * UNMAPPED + 4
                              + NUM_TEAMS * TEAM_REGS + 1;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    nebula_pkg::sel_t      sel;
    nebula_pkg::addr_t     adr;
    nebula_pkg::word_t     wdat;
    logic                  ack;
    nebula_pkg::word_t     rdat;
    nebula_pkg::pin_vec_t  io_in;
    nebula_pkg::pin_vec_t  io_out;
    nebula_pkg::pin_vec_t  io_oeb;

    // Register model
    nebula_pkg::team_idx_t m_sel;
    nebula_pkg::pin_vec_t  m_out [NUM_TEAMS];
    nebula_pkg::pin_vec_t  m_oeb [NUM_TEAMS];
    nebula_pkg::word_t     m_inv [NUM_TEAMS];
    nebula_pkg::word_t     sram_model [`NEBULA_SRAM_DEPTH];

    logic                  bus_busy = 1'b0;
    logic                  pads_live = 1'b0;
    int                    pad_samples = 0;
    nebula_pkg::gpio_bus_t exp_pads;

    nebula_top DUT (
        .wb_clk_i (clk),
        .rst_i    (rst),
        .wbs_cyc_i(cyc),
        .wbs_stb_i(stb),
        .wbs_we_i (we),
        .wbs_sel_i(sel),
        .wbs_adr_i(adr),
        .wbs_dat_i(wdat),
        .wbs_ack_o(ack),
        .wbs_dat_o(rdat),
        .io_in_i  (io_in),
        .io_out_o (io_out),
        .io_oeb_o (io_oeb)
    );

    always #4 clk = ~clk; // 8 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input nebula_pkg::word_t exp,
                              input nebula_pkg::word_t act);
        if (act !== exp) abort_run($sformatf("ERROR at %0t ns: %s expected %h, got %h",
                                             $time, name, exp, act));
    endtask

    task automatic check_pins(input string name, input nebula_pkg::pin_vec_t exp,
                              input nebula_pkg::pin_vec_t act);
        if (act !== exp) abort_run($sformatf("ERROR at %0t ns: %s expected %h, got %h",
                                             $time, name, exp, act));
    endtask

    task automatic check_ack(input int cycles);
        if (cycles != 1) begin
            abort_run($sformatf("ERROR at %0t ns: wbs_ack_o latency expected 1, got %0d",
                                $time, cycles));
        end
    endtask

    function automatic nebula_pkg::word_t merge_lanes(input nebula_pkg::word_t old_w,
                                                      input nebula_pkg::word_t new_w,
                                                      input nebula_pkg::sel_t s);
        nebula_pkg::word_t mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic nebula_pkg::addr_t slot_addr(input int slot, input int byte_off);
        return nebula_pkg::addr_t'((slot << `NEBULA_SLOT_LSB) | byte_off);
    endfunction

    function automatic nebula_pkg::word_t team_reg_value(input int t, input int r);
        case (r)
            0: return m_out[t][31:0];
            1: return nebula_pkg::word_t'(m_out[t][GPIO_W-1:32]);
            2: return m_oeb[t][31:0];
            3: return nebula_pkg::word_t'(m_oeb[t][GPIO_W-1:32]);
            4: return m_inv[t];
            5: return io_in[31:0]; // PINS
            default: return '0;
        endcase
    endfunction

    task automatic team_model_write(input int t, input int r, input nebula_pkg::word_t d,
                                    input nebula_pkg::sel_t s);
        nebula_pkg::word_t nw;
        nw = merge_lanes(team_reg_value(t, r), d, s);
        case (r)
            0: m_out[t][31:0] = nw;
            1: m_out[t][GPIO_W-1:32] = nw[GPIO_W-33:0];
            2: m_oeb[t][31:0] = nw;
            3: m_oeb[t][GPIO_W-1:32] = nw[GPIO_W-33:0];
            4: m_inv[t] = nw;
            default: ;
        endcase
    endtask

    // Expected pads from the register model
    function automatic nebula_pkg::gpio_bus_t expected_pads(input nebula_pkg::pin_vec_t pins);
        nebula_pkg::gpio_bus_t res;
        int t;
        res.out = '0;
        res.oeb = '1; // No team, every pad is an input
        if (m_sel != 0 && int'(m_sel) <= NUM_TEAMS) begin
            t = int'(m_sel) - 1;
            res.out = m_out[t] ^ nebula_pkg::pin_vec_t'(pins[31:0] & m_inv[t]);
            res.oeb = m_oeb[t];
        end
        return res;
    endfunction

    // One Wishbone classic cycle, inputs move 1 ns after the edge
    task automatic wb_access(input logic write, input nebula_pkg::addr_t a,
                             input nebula_pkg::word_t d, input nebula_pkg::sel_t s,
                             output nebula_pkg::word_t rd);
        int cycles;
        @(posedge clk);
        #1;
        bus_busy = 1'b1;
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        sel = s;
        adr = a;
        wdat = d;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (!ack && cycles > 4) abort_run($sformatf("no ack for address %h", a));
        end while (!ack);
        rd = rdat;
        check_ack(cycles);
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        bus_busy = 1'b0;
    endtask

    task automatic wb_write(input nebula_pkg::addr_t a, input nebula_pkg::word_t d,
                            input nebula_pkg::sel_t s);
        nebula_pkg::word_t discard;
        wb_access(1'b1, a, d, s, discard);
    endtask

    task automatic wb_read(input nebula_pkg::addr_t a, output nebula_pkg::word_t rd);
        wb_access(1'b0, a, '0, 4'hf, rd);
    endtask

    task automatic check_sram(input int k);
        nebula_pkg::word_t rd;
        wb_read(slot_addr(`NEBULA_SLOT_SRAM, k * 4), rd);
        check_word($sformatf("wbs_dat_o sram[%0d]", k), sram_model[k], rd);
    endtask

    task automatic check_team_reg(input int t, input int r);
        nebula_pkg::word_t rd;
        wb_read(slot_addr(`NEBULA_SLOT_TEAM0 + t, r * 4), rd);
        check_word($sformatf("wbs_dat_o team%0d reg%0d", t, r), team_reg_value(t, r), rd);
    endtask

    // Pad compare, skipped while a register write may be landing
    always @(negedge clk) begin
        if (DUT.u_props.fail_count != 0) abort_run("a bound property on nebula_top failed");
        if (pads_live && !bus_busy) begin
            exp_pads = expected_pads(io_in);
            check_pins("io_out_o", exp_pads.out, io_out);
            check_pins("io_oeb_o", exp_pads.oeb, io_oeb);
            pad_samples++;
        end
    end

    initial begin : watchdog
        repeat (NUM_TXNS * 4 + 100) @(posedge clk);
        abort_run("watchdog expired, the bus hung");
    end

    initial begin : main_seq
        nebula_pkg::word_t rd;
        nebula_pkg::word_t d;
        nebula_pkg::sel_t  s;
        nebula_pkg::addr_t a;
        int                idx_list [SRAM_WORDS];
        int                k;
        int                off;
        void'($urandom(25361));
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        sel = '0;
        adr = '0;
        wdat = '0;
        io_in = '0;
        m_sel = '0;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            m_out[t] = '0;
            m_oeb[t] = '1;
            m_inv[t] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        pads_live = 1'b1;

        check_pins("io_out_o", '0, io_out);
        check_pins("io_oeb_o", '1, io_oeb);
        wb_read(slot_addr(`NEBULA_SLOT_GPIO, 0), rd);
        check_word("wbs_dat_o gpio select", '0, rd);

        // SRAM fill, then partial lane updates
        for (int i = 0; i < SRAM_WORDS; i++) begin
            idx_list[i] = i * 16 + int'($urandom % 16);
            d = $urandom;
            wb_write(slot_addr(`NEBULA_SLOT_SRAM, idx_list[i] * 4), d, 4'hf);
            sram_model[idx_list[i]] = d;
        end
        for (int i = 0; i < SRAM_PATCHES; i++) begin
            k = idx_list[$urandom % SRAM_WORDS];
            d = $urandom;
            s = nebula_pkg::sel_t'($urandom);
            wb_write(slot_addr(`NEBULA_SLOT_SRAM, k * 4), d, s);
            sram_model[k] = merge_lanes(sram_model[k], d, s);
        end
        for (int i = 0; i < SRAM_WORDS; i++) check_sram(idx_list[i]);

        for (int t = 0; t < NUM_TEAMS; t++) begin
            for (int r = 0; r < TEAM_REGS; r++) begin
                d = $urandom;
                s = nebula_pkg::sel_t'($urandom);
                wb_write(slot_addr(`NEBULA_SLOT_TEAM0 + t, r * 4), d, s);
                team_model_write(t, r, d, s);
            end
            for (int r = 0; r < TEAM_REGS; r++) check_team_reg(t, r);
            io_in = nebula_pkg::pin_vec_t'({$urandom, $urandom});
            check_team_reg(t, 5);
        end

        // Every select value with fresh pad inputs
        for (int sv = 0; sv < 4; sv++) begin
            wb_write(slot_addr(`NEBULA_SLOT_GPIO, 0), nebula_pkg::word_t'(sv), 4'hf);
            m_sel = nebula_pkg::team_idx_t'(sv);
            wb_read(slot_addr(`NEBULA_SLOT_GPIO, 0), rd);
            check_word("wbs_dat_o gpio select", nebula_pkg::word_t'(sv), rd);
            for (int i = 0; i < PAD_SAMPLES; i++) begin
                io_in = nebula_pkg::pin_vec_t'({$urandom, $urandom});
                @(posedge clk);
                #1;
            end
        end

        // Unmapped slots alias onto register offsets
        for (int u = 0; u < UNMAPPED; u++) begin
            case (u)
                0: off = 0; // GPIO select and team OUT
                1: off = 4 * (1 + int'($urandom % (TEAM_REGS - 1)));
                default: off = 4 * idx_list[0]; // A modeled SRAM word
            endcase
            a = slot_addr((u == 1) ? 15 : NUM_SUBS, off);
            d = $urandom & 32'hffff_fffc; // Low bits clear, unlike the live select
            wb_write(a, d, 4'hf);
            wb_read(a, rd);
            check_word($sformatf("wbs_dat_o unmapped %h", a), '0, rd);
        end
        for (int i = 0; i < 4; i++) check_sram(idx_list[i]);
        for (int t = 0; t < NUM_TEAMS; t++) begin
            for (int r = 0; r < TEAM_REGS; r++) check_team_reg(t, r);
        end
        wb_read(slot_addr(`NEBULA_SLOT_GPIO, 0), rd);
        check_word("wbs_dat_o gpio select", nebula_pkg::word_t'(m_sel), rd);

        repeat (2) @(negedge clk);
        if (pad_samples == 0 || DUT.u_props.fail_count != 0) begin
            abort_run("pad compare never ran or a bound property failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/nebula_props.sv
// User area bus and pad properties
// Bound into nebula_top, watches the ack handshake and the pad state after reset

`default_nettype none

module nebula_props (
    input wire                  wb_clk_i,
    input wire                  rst_i,
    input wire                  cyc_i,
    input wire                  stb_i,
    input wire                  ack_i,
    input nebula_pkg::pin_vec_t oeb_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0; // Read by the testbench

    // Ack answers a request seen on the previous edge
    ack_after_req: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        ack_i |-> $past(cyc_i && stb_i))
    else begin
        $error("ack raised without cyc and stb in the previous cycle");
        fail_count++;
    end

    ack_single: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        ack_i |=> !ack_i)
    else begin
        $error("ack held high for two cycles");
        fail_count++;
    end

    oeb_reset: assert property (@(posedge wb_clk_i) rst_i |=> (oeb_i == '1))
    else begin
        $error("pad output enables active right after reset");
        fail_count++;
    end

endmodule

bind nebula_top nebula_props u_props (
    .wb_clk_i(wb_clk_i),
    .rst_i   (rst_i),
    .cyc_i   (wbs_cyc_i),
    .stb_i   (wbs_stb_i),
    .ack_i   (wbs_ack_o),
    .oeb_i   (io_oeb_o)
);

`default_nettype wire

//--- logic/nebula_top.sv
// Nebula user area top
// Decoder, SRAM, GPIO control and the generated team slots

`default_nettype none

`include "nebula_defs.svh"

module nebula_top (
    input  wire                  wb_clk_i,
    input  wire                  rst_i,

    // Wishbone subordinate port
    input  wire                  wbs_cyc_i,
    input  wire                  wbs_stb_i,
    input  wire                  wbs_we_i,
    input  nebula_pkg::sel_t     wbs_sel_i,
    input  nebula_pkg::addr_t    wbs_adr_i,
    input  nebula_pkg::word_t    wbs_dat_i,
    output logic                 wbs_ack_o,
    output nebula_pkg::word_t    wbs_dat_o,

    // Pads
    input  nebula_pkg::pin_vec_t io_in_i,
    output nebula_pkg::pin_vec_t io_out_o,
    output nebula_pkg::pin_vec_t io_oeb_o
);

    nebula_pkg::wb_req_t   host_req;
    nebula_pkg::wb_rsp_t   host_rsp;
    nebula_pkg::wb_req_t   sub_req [`NEBULA_NUM_SUBS];
    nebula_pkg::wb_rsp_t   sub_rsp [`NEBULA_NUM_SUBS];
    nebula_pkg::gpio_bus_t team_gpio [`NEBULA_NUM_TEAMS];

    assign host_req = '{cyc: wbs_cyc_i, stb: wbs_stb_i, we: wbs_we_i,
                        sel: wbs_sel_i, adr: wbs_adr_i, dat: wbs_dat_i};
    assign wbs_ack_o = host_rsp.ack;
    assign wbs_dat_o = host_rsp.dat;

    wb_decoder u_decoder (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .req_i    (host_req),
        .rsp_o    (host_rsp),
        .sub_req_o(sub_req),
        .sub_rsp_i(sub_rsp)
    );

    wb_sram u_sram (
        .wb_clk_i(wb_clk_i),
        .rst_i   (rst_i),
        .req_i   (sub_req[`NEBULA_SLOT_SRAM]),
        .rsp_o   (sub_rsp[`NEBULA_SLOT_SRAM])
    );

    gpio_control u_gpio_control (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .req_i      (sub_req[`NEBULA_SLOT_GPIO]),
        .rsp_o      (sub_rsp[`NEBULA_SLOT_GPIO]),
        .team_gpio_i(team_gpio),
        .io_out_o   (io_out_o),
        .io_oeb_o   (io_oeb_o)
    );

    // One register slot per team
    for (genvar t = 0; t < `NEBULA_NUM_TEAMS; t++) begin : g_team
        team_slot u_team (
            .wb_clk_i(wb_clk_i),
            .rst_i   (rst_i),
            .req_i   (sub_req[`NEBULA_SLOT_TEAM0 + t]),
            .rsp_o   (sub_rsp[`NEBULA_SLOT_TEAM0 + t]),
            .pins_i  (io_in_i),
            .gpio_o  (team_gpio[t])
        );
    end

endmodule

`default_nettype wire

//--- logic/wb_sram.sv
// Wishbone SRAM
// Word array with byte-lane writes and a registered read port

`default_nettype none

`include "nebula_defs.svh"

module wb_sram (
    input  wire                 wb_clk_i,
    input  wire                 rst_i,
    input  nebula_pkg::wb_req_t req_i,
    output nebula_pkg::wb_rsp_t rsp_o
);

    localparam int DEPTH = `NEBULA_SRAM_DEPTH;
    localparam int AW = $clog2(DEPTH);

    nebula_pkg::word_t mem [DEPTH];

    logic              ack_q;
    nebula_pkg::word_t rdata_q;
    logic              access;
    logic [AW-1:0]     idx;

    assign access = req_i.cyc & req_i.stb & ~ack_q;
    assign idx    = req_i.adr[AW+1:2]; // Word address

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Contents and read data carry no reset
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            rdata_q <= mem[idx];
            if (req_i.we) begin
                mem[idx] <= nebula_pkg::byte_merge(mem[idx], req_i.dat, req_i.sel);
            end
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

//--- logic/gpio_control.sv
// GPIO control
// Select register picking which team drives the pads

`default_nettype none

`include "nebula_defs.svh"

module gpio_control (
    input  wire                   wb_clk_i,
    input  wire                   rst_i,
    input  nebula_pkg::wb_req_t   req_i,
    output nebula_pkg::wb_rsp_t   rsp_o,
    input  nebula_pkg::gpio_bus_t team_gpio_i [`NEBULA_NUM_TEAMS],
    output nebula_pkg::pin_vec_t  io_out_o,
    output nebula_pkg::pin_vec_t  io_oeb_o
);

    localparam int SEL_W = $bits(nebula_pkg::team_idx_t);

    nebula_pkg::team_idx_t sel_q;
    logic                  ack_q;
    nebula_pkg::word_t     rdata_q;
    logic                  access;
    logic                  hit; // Offset 0x0
    nebula_pkg::word_t     cur_word;
    nebula_pkg::word_t     wr_word;
    nebula_pkg::gpio_bus_t pads;

    assign access   = req_i.cyc & req_i.stb & ~ack_q;
    assign hit      = (req_i.adr[`NEBULA_SLOT_LSB-1:2] == '0);
    assign cur_word = hit ? {{(32-SEL_W){1'b0}}, sel_q} : '0;
    assign wr_word  = nebula_pkg::byte_merge(cur_word, req_i.dat, req_i.sel);

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            sel_q <= '0; // No team on the pads
        end else begin
            ack_q <= access;
            if (access && req_i.we && hit) sel_q <= wr_word[SEL_W-1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) rdata_q <= cur_word;
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

    // Out-of-range select falls through to the idle default
    always_comb begin
        pads.out = '0;
        pads.oeb = '1;
        for (int k = 0; k < `NEBULA_NUM_TEAMS; k++) begin
            if (sel_q == SEL_W'(k + 1)) pads = team_gpio_i[k];
        end
    end

    assign io_out_o = pads.out;
    assign io_oeb_o = pads.oeb;

endmodule

`default_nettype wire

//--- logic/team_slot.sv
// Team register slot
// Pad output, output enable and input inversion registers on Wishbone

`default_nettype none

`include "nebula_defs.svh"

module team_slot (
    input  wire                  wb_clk_i,
    input  wire                  rst_i,
    input  nebula_pkg::wb_req_t  req_i,
    output nebula_pkg::wb_rsp_t  rsp_o,
    input  nebula_pkg::pin_vec_t pins_i,
    output nebula_pkg::gpio_bus_t gpio_o
);

    localparam int HI_W = `NEBULA_GPIO_W - 32;
    localparam int IDX_W = `NEBULA_SLOT_LSB - 2;

    // Word offsets
    localparam logic [IDX_W-1:0] REG_OUT    = IDX_W'(0);
    localparam logic [IDX_W-1:0] REG_OUT_HI = IDX_W'(1);
    localparam logic [IDX_W-1:0] REG_OEB    = IDX_W'(2);
    localparam logic [IDX_W-1:0] REG_OEB_HI = IDX_W'(3);
    localparam logic [IDX_W-1:0] REG_INV    = IDX_W'(4);
    localparam logic [IDX_W-1:0] REG_PINS   = IDX_W'(5);

    nebula_pkg::word_t out_q;
    logic [HI_W-1:0]   out_hi_q;
    nebula_pkg::word_t oeb_q;
    logic [HI_W-1:0]   oeb_hi_q;
    nebula_pkg::word_t inv_q;

    logic              ack_q;
    nebula_pkg::word_t rdata_q;
    logic              access;
    logic [IDX_W-1:0]  reg_idx;
    nebula_pkg::word_t cur_word; // Addressed register, zero padded
    nebula_pkg::word_t wr_word;

    assign access  = req_i.cyc & req_i.stb & ~ack_q;
    assign reg_idx = req_i.adr[`NEBULA_SLOT_LSB-1:2];

    always_comb begin
        case (reg_idx)
            REG_OUT:    cur_word = out_q;
            REG_OUT_HI: cur_word = {{(32-HI_W){1'b0}}, out_hi_q};
            REG_OEB:    cur_word = oeb_q;
            REG_OEB_HI: cur_word = {{(32-HI_W){1'b0}}, oeb_hi_q};
            REG_INV:    cur_word = inv_q;
            REG_PINS:   cur_word = pins_i[31:0];
            default:    cur_word = '0; // Unknown offset reads zero
        endcase
    end

    assign wr_word = nebula_pkg::byte_merge(cur_word, req_i.dat, req_i.sel);

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q    <= 1'b0;
            out_q    <= '0;
            out_hi_q <= '0;
            oeb_q    <= '1; // Pads start as inputs
            oeb_hi_q <= '1;
            inv_q    <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                case (reg_idx)
                    REG_OUT:    out_q    <= wr_word;
                    REG_OUT_HI: out_hi_q <= wr_word[HI_W-1:0];
                    REG_OEB:    oeb_q    <= wr_word;
                    REG_OEB_HI: oeb_hi_q <= wr_word[HI_W-1:0];
                    REG_INV:    inv_q    <= wr_word;
                    default:    ; // PINS is read-only
                endcase
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge wb_clk_i) begin
        if (access) rdata_q <= cur_word;
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rdata_q;

    // Inversion applies to the low 32 pads only
    assign gpio_o.out = {out_hi_q, out_q ^ (pins_i[31:0] & inv_q)};
    assign gpio_o.oeb = {oeb_hi_q, oeb_q};

endmodule

`default_nettype wire

//--- logic/wb_decoder.sv
// Wishbone address decoder
// Routes stb to one subordinate by slot field, muxes the response back

`default_nettype none

`include "nebula_defs.svh"

module wb_decoder (
    input  wire                 wb_clk_i,
    input  wire                 rst_i,
    input  nebula_pkg::wb_req_t req_i,
    output nebula_pkg::wb_rsp_t rsp_o,
    output nebula_pkg::wb_req_t sub_req_o [`NEBULA_NUM_SUBS],
    input  nebula_pkg::wb_rsp_t sub_rsp_i [`NEBULA_NUM_SUBS]
);

    localparam int SLOT_W = `NEBULA_SLOT_W;
    localparam int NUM_SUBS = `NEBULA_NUM_SUBS;

    logic [SLOT_W-1:0] slot;
    logic              miss;
    logic              miss_ack_q;

    assign slot = req_i.adr[`NEBULA_SLOT_LSB +: SLOT_W];
    assign miss = (slot >= SLOT_W'(NUM_SUBS)); // Past the last team

    // Everyone sees the bus, only the addressed one sees stb
    always_comb begin
        for (int i = 0; i < NUM_SUBS; i++) begin
            sub_req_o[i]     = req_i;
            sub_req_o[i].stb = req_i.stb & (slot == SLOT_W'(i));
        end
    end

    // Unmapped slots answer on their own so the bus never hangs
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            miss_ack_q <= 1'b0;
        end else begin
            miss_ack_q <= req_i.cyc & req_i.stb & miss & ~miss_ack_q;
        end
    end

    // Response path, no register
    always_comb begin
        rsp_o.ack = miss_ack_q;
        rsp_o.dat = '0; // Zero data for a miss
        for (int i = 0; i < NUM_SUBS; i++) begin
            if (slot == SLOT_W'(i)) begin
                rsp_o = sub_rsp_i[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/nebula_pkg.sv
// Nebula shared types
// Bus and pad vectors, Wishbone and GPIO bundles, byte-lane merge

`default_nettype none

`include "nebula_defs.svh"

package nebula_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0] sel_t;
    typedef logic [`NEBULA_GPIO_W-1:0] pin_vec_t;
    typedef logic [1:0] team_idx_t; // 0 is no team, k is team k-1

    // Manager to subordinate
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        sel_t  sel;
        addr_t adr;
        word_t dat;
    } wb_req_t;

    // Subordinate to manager
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        pin_vec_t out;
        pin_vec_t oeb; // Active low enable
    } gpio_bus_t;

    // Replace the lanes of old_w picked by sel with new_w
    function automatic word_t byte_merge(input word_t old_w, input word_t new_w, input sel_t sel);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- logic/nebula_defs.svh
// Nebula user area constants
// Team count, pad width, SRAM size and the Wishbone slot map

`ifndef NEBULA_DEFS_SVH
`define NEBULA_DEFS_SVH

// Team slots built in the generate loop
`define NEBULA_NUM_TEAMS 3

// Caravel style pad count
`define NEBULA_GPIO_W 38

`define NEBULA_SRAM_DEPTH 256 // 32-bit words

// Slot field sits in adr[19:16]
`define NEBULA_SLOT_LSB 16
`define NEBULA_SLOT_W 4

`define NEBULA_SLOT_SRAM 0
`define NEBULA_SLOT_GPIO 1
`define NEBULA_SLOT_TEAM0 2 // Team k lives at this slot plus k

// Subordinates behind the decoder, SRAM and GPIO first
`define NEBULA_NUM_SUBS (`NEBULA_SLOT_TEAM0 + `NEBULA_NUM_TEAMS)

`endif
